// ==== hw/corr_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Array geometry of the sign-sample lag correlator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package corr_cfg_pkg;

	localparam int NUM_INPUTS_DEF = 3;  // receiver inputs.
	localparam int NUM_LAGS_DEF = 4;    // lags 0 to 3.
	localparam int QUAD_SHIFT_DEF = 1;  // extra delay of the quadrature tap.
	localparam int ACC_WIDTH_DEF = 16;

	// pairs i<j out of n inputs.
	function automatic int num_baselines(input int n);
		return (n * (n - 1)) / 2;
	endfunction

	// first input of a baseline, pairs ordered (0,1),(0,2),(1,2)...
	function automatic int base_in_a(input int idx, input int n);
		int cnt;
		int res;
		cnt = 0;
		res = 0;
		for (int a = 0; a < n; a++) begin
			for (int b = a + 1; b < n; b++) begin
				if (cnt == idx) res = a;
				cnt++;
			end
		end
		return res;
	endfunction

	function automatic int base_in_b(input int idx, input int n);
		int cnt;
		int res;
		cnt = 0;
		res = 0;
		for (int a = 0; a < n; a++) begin
			for (int b = a + 1; b < n; b++) begin
				if (cnt == idx) res = b;
				cnt++;
			end
		end
		return res;
	endfunction

endpackage

// ==== hw/corr_stream_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output stream word of the correlator readout.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package corr_stream_pkg;

	// first word of every frame.
	typedef struct packed {
		logic [15:0] frame_cnt; // frames sent since reset.
		logic [15:0] samp_cnt;  // frame length in samples.
	} corr_hdr_t;

	// one baseline and lag.
	typedef struct packed {
		logic signed [15:0] re;
		logic signed [15:0] im;
	} corr_data_t;

	typedef union packed {
		corr_hdr_t  hdr;
		corr_data_t data;
	} corr_word_u;

endpackage

// ==== hw/corr_tap_line.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample input stage with per-input tap lines.
// Counts the frame and closes the input after its last sample.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module corr_tap_line #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int NUM_LAGS = corr_cfg_pkg::NUM_LAGS_DEF,
	parameter int QUAD_SHIFT = corr_cfg_pkg::QUAD_SHIFT_DEF
) (
	input  logic                                       clk,
	input  logic                                       rst_n_i,
	input  logic                                       enable_i,
	input  logic [15:0]                                integ_len_i,
	input  logic                                       in_valid_i,
	input  logic [NUM_INPUTS-1:0]                      in_samp_i,
	output logic                                       in_ready_o,
	input  logic                                       frame_done_i,
	output logic                                       tap_valid_o,
	output logic [NUM_INPUTS*(NUM_LAGS+QUAD_SHIFT)-1:0] taps_o,
	output logic                                       tap_last_o
);
	localparam int TAP_DEPTH = NUM_LAGS + QUAD_SHIFT;

	logic [TAP_DEPTH-1:0] line_q [NUM_INPUTS];
	logic [15:0]          samp_cnt_q;
	logic                 open_q;
	logic                 hold_q; // last sample taken, waiting for frame_done.
	logic                 in_fire;
	logic                 last_samp;

	assign in_ready_o = enable_i & open_q;
	assign in_fire = in_valid_i & in_ready_o;
	assign last_samp = (samp_cnt_q + 16'd1) == integ_len_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tap lines, bit 0 holds the newest sample
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_line
		always_ff @(posedge clk or negedge rst_n_i) begin
			if (!rst_n_i) begin
				line_q[i] <= '0;
			end else if (in_fire) begin
				line_q[i] <= {line_q[i][TAP_DEPTH-2:0], in_samp_i[i]};
			end
		end
		assign taps_o[i*TAP_DEPTH +: TAP_DEPTH] = line_q[i];
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			samp_cnt_q <= '0;
			open_q <= 1'b0;
			hold_q <= 1'b0;
			tap_valid_o <= 1'b0;
			tap_last_o <= 1'b0;
		end else begin
			tap_valid_o <= in_fire;
			tap_last_o <= in_fire & last_samp;
			if (in_fire) samp_cnt_q <= last_samp ? 16'd0 : samp_cnt_q + 16'd1;
			if (in_fire && last_samp) begin
				hold_q <= 1'b1;
				open_q <= 1'b0;
			end else if (frame_done_i) begin
				hold_q <= 1'b0;
				open_q <= 1'b1; // snapshot taken, next frame may start.
			end else begin
				open_q <= ~hold_q;
			end
		end
	end

endmodule

// ==== hw/corr_lag_mult.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lag-multiply stage with registered sign products.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module corr_lag_mult #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int NUM_LAGS = corr_cfg_pkg::NUM_LAGS_DEF,
	parameter int QUAD_SHIFT = corr_cfg_pkg::QUAD_SHIFT_DEF
) (
	input  logic                                                      clk,
	input  logic                                                      rst_n_i,
	input  logic                                                      tap_valid_i,
	input  logic [NUM_INPUTS*(NUM_LAGS+QUAD_SHIFT)-1:0]                taps_i,
	input  logic                                                      tap_last_i,
	output logic                                                      prod_valid_o,
	output logic [corr_cfg_pkg::num_baselines(NUM_INPUTS)*NUM_LAGS-1:0] prod_re_o,
	output logic [corr_cfg_pkg::num_baselines(NUM_INPUTS)*NUM_LAGS-1:0] prod_im_o,
	output logic                                                      prod_last_o
);
	localparam int TAP_DEPTH = NUM_LAGS + QUAD_SHIFT;
	localparam int NUM_BASELINES = corr_cfg_pkg::num_baselines(NUM_INPUTS);
	localparam int NUM_PRODS = NUM_BASELINES * NUM_LAGS;

	logic [NUM_PRODS-1:0] re_d;
	logic [NUM_PRODS-1:0] im_d;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sign products, xnor is the 1-bit multiply
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar bl = 0; bl < NUM_BASELINES; bl++) begin : g_bl
		localparam int IN_A = corr_cfg_pkg::base_in_a(bl, NUM_INPUTS);
		localparam int IN_B = corr_cfg_pkg::base_in_b(bl, NUM_INPUTS);
		for (genvar k = 0; k < NUM_LAGS; k++) begin : g_lag
			assign re_d[bl*NUM_LAGS + k] =
				~(taps_i[IN_A*TAP_DEPTH] ^ taps_i[IN_B*TAP_DEPTH + k]);
			assign im_d[bl*NUM_LAGS + k] =
				~(taps_i[IN_A*TAP_DEPTH] ^ taps_i[IN_B*TAP_DEPTH + k + QUAD_SHIFT]); // quadrature tap.
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			prod_valid_o <= 1'b0;
			prod_last_o <= 1'b0;
		end else begin
			prod_valid_o <= tap_valid_i;
			prod_last_o <= tap_valid_i & tap_last_i;
		end
	end

	always_ff @(posedge clk) begin
		if (tap_valid_i) begin
			prod_re_o <= re_d;
			prod_im_o <= im_d;
		end
	end

endmodule

// ==== hw/corr_accum.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Saturating frame accumulators and snapshot hand-off.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module corr_accum #(
	parameter int NUM_BASELINES = corr_cfg_pkg::num_baselines(corr_cfg_pkg::NUM_INPUTS_DEF),
	parameter int NUM_LAGS = corr_cfg_pkg::NUM_LAGS_DEF,
	parameter int ACC_WIDTH = corr_cfg_pkg::ACC_WIDTH_DEF
) (
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  logic                                    prod_valid_i,
	input  logic [NUM_BASELINES*NUM_LAGS-1:0]       prod_re_i,
	input  logic [NUM_BASELINES*NUM_LAGS-1:0]       prod_im_i,
	input  logic                                    prod_last_i,
	output logic                                    snap_valid_o,
	input  logic                                    snap_ready_i,
	output logic [NUM_BASELINES*NUM_LAGS*ACC_WIDTH-1:0] snap_re_o,
	output logic [NUM_BASELINES*NUM_LAGS*ACC_WIDTH-1:0] snap_im_o,
	output logic                                    frame_done_o
);
	localparam int NUM_PRODS = NUM_BASELINES * NUM_LAGS;
	localparam logic signed [ACC_WIDTH-1:0] ACC_MAX = {1'b0, {(ACC_WIDTH-1){1'b1}}};
	localparam logic signed [ACC_WIDTH-1:0] ACC_MIN = {1'b1, {(ACC_WIDTH-1){1'b0}}};
	localparam logic signed [ACC_WIDTH-1:0] ACC_ONE = 1;

	logic signed [ACC_WIDTH-1:0] acc_re_q [NUM_PRODS];
	logic signed [ACC_WIDTH-1:0] acc_im_q [NUM_PRODS];
	logic                        snap_valid_q;
	logic                        snap_take;

	// one +1/-1 step that sticks at the rails.
	function automatic logic signed [ACC_WIDTH-1:0] sat_step(
		input logic signed [ACC_WIDTH-1:0] acc,
		input logic                        up
	);
		if (up) begin
			return (acc == ACC_MAX) ? acc : acc + ACC_ONE;
		end
		return (acc == ACC_MIN) ? acc : acc - ACC_ONE;
	endfunction

	assign snap_valid_o = snap_valid_q;
	assign snap_take = snap_valid_q & snap_ready_i;
	assign frame_done_o = snap_take; // readout copies the sums this cycle.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// accumulator lanes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar p = 0; p < NUM_PRODS; p++) begin : g_lane
		always_ff @(posedge clk or negedge rst_n_i) begin
			if (!rst_n_i) begin
				acc_re_q[p] <= '0;
				acc_im_q[p] <= '0;
			end else if (snap_take) begin
				acc_re_q[p] <= '0; // fresh frame.
				acc_im_q[p] <= '0;
			end else if (prod_valid_i) begin
				acc_re_q[p] <= sat_step(acc_re_q[p], prod_re_i[p]);
				acc_im_q[p] <= sat_step(acc_im_q[p], prod_im_i[p]);
			end
		end
		assign snap_re_o[p*ACC_WIDTH +: ACC_WIDTH] = acc_re_q[p];
		assign snap_im_o[p*ACC_WIDTH +: ACC_WIDTH] = acc_im_q[p];
	end

	// sums stay put while waiting, the input is closed by then.
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			snap_valid_q <= 1'b0;
		end else if (snap_take) begin
			snap_valid_q <= 1'b0;
		end else if (prod_valid_i && prod_last_i) begin
			snap_valid_q <= 1'b1;
		end
	end

endmodule

// ==== hw/corr_readout.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Snapshot buffer and frame serializer.
// Sends a header word, then one word per baseline and lag.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module corr_readout #(
	parameter int NUM_BASELINES = corr_cfg_pkg::num_baselines(corr_cfg_pkg::NUM_INPUTS_DEF),
	parameter int NUM_LAGS = corr_cfg_pkg::NUM_LAGS_DEF,
	parameter int ACC_WIDTH = corr_cfg_pkg::ACC_WIDTH_DEF
) (
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  logic [15:0]                             integ_len_i,
	input  logic                                    snap_valid_i,
	input  logic [NUM_BASELINES*NUM_LAGS*ACC_WIDTH-1:0] snap_re_i,
	input  logic [NUM_BASELINES*NUM_LAGS*ACC_WIDTH-1:0] snap_im_i,
	output logic                                    snap_ready_o,
	output logic                                    out_valid_o,
	input  logic                                    out_ready_i,
	output corr_stream_pkg::corr_word_u             out_word_o,
	output logic                                    out_hdr_o
);
	localparam int NUM_PRODS = NUM_BASELINES * NUM_LAGS;
	localparam int NUM_WORDS = NUM_PRODS + 1;
	localparam int IDX_W = $clog2(NUM_WORDS);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_WORDS - 1);
	localparam logic [IDX_W-1:0] IDX_ONE = 1;

	logic signed [ACC_WIDTH-1:0] buf_re_q [NUM_PRODS];
	logic signed [ACC_WIDTH-1:0] buf_im_q [NUM_PRODS];
	logic [15:0]                 samp_len_q;
	logic [15:0]                 frame_cnt_q;
	logic [IDX_W-1:0]            word_idx_q; // 0 is the header.
	logic [IDX_W-1:0]            rd_sel;
	logic                        busy_q;
	logic                        snap_take;
	logic                        out_fire;

	assign snap_ready_o = ~busy_q;
	assign snap_take = snap_valid_i & snap_ready_o;
	assign out_valid_o = busy_q;
	assign out_fire = out_valid_o & out_ready_i;
	assign out_hdr_o = busy_q & (word_idx_q == '0);
	assign rd_sel = word_idx_q - IDX_ONE;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// snapshot buffer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (snap_take) begin
			for (int p = 0; p < NUM_PRODS; p++) begin
				buf_re_q[p] <= snap_re_i[p*ACC_WIDTH +: ACC_WIDTH];
				buf_im_q[p] <= snap_im_i[p*ACC_WIDTH +: ACC_WIDTH];
			end
			samp_len_q <= integ_len_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			word_idx_q <= '0;
			frame_cnt_q <= '0;
		end else if (snap_take) begin
			busy_q <= 1'b1;
			word_idx_q <= '0;
		end else if (out_fire) begin
			if (word_idx_q == IDX_LAST) begin
				busy_q <= 1'b0; // frame fully sent.
				frame_cnt_q <= frame_cnt_q + 16'd1;
			end else begin
				word_idx_q <= word_idx_q + IDX_ONE;
			end
		end
	end

	// word view chosen by the index, held while stalled.
	always_comb begin
		out_word_o = '0;
		if (word_idx_q == '0) begin
			out_word_o.hdr.frame_cnt = frame_cnt_q;
			out_word_o.hdr.samp_cnt = samp_len_q;
		end else begin
			out_word_o.data.re = 16'(buf_re_q[rd_sel]); // sign-extended.
			out_word_o.data.im = 16'(buf_im_q[rd_sel]);
		end
	end

endmodule

// ==== hw/corr_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the 1-bit lag correlator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module corr_top #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int NUM_LAGS = corr_cfg_pkg::NUM_LAGS_DEF,
	parameter int QUAD_SHIFT = corr_cfg_pkg::QUAD_SHIFT_DEF,
	parameter int ACC_WIDTH = corr_cfg_pkg::ACC_WIDTH_DEF
) (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        enable_i,
	input  logic [15:0]                 integ_len_i,
	input  logic                        in_valid_i,
	input  logic [NUM_INPUTS-1:0]       in_samp_i,
	output logic                        in_ready_o,
	output logic                        out_valid_o,
	input  logic                        out_ready_i,
	output corr_stream_pkg::corr_word_u out_word_o,
	output logic                        out_hdr_o
);
	localparam int NUM_BASELINES = corr_cfg_pkg::num_baselines(NUM_INPUTS);
	localparam int NUM_PRODS = NUM_BASELINES * NUM_LAGS;
	localparam int TAP_DEPTH = NUM_LAGS + QUAD_SHIFT;

	logic                           tap_valid;
	logic [NUM_INPUTS*TAP_DEPTH-1:0] taps;
	logic                           tap_last;
	logic                           prod_valid;
	logic [NUM_PRODS-1:0]           prod_re;
	logic [NUM_PRODS-1:0]           prod_im;
	logic                           prod_last;
	logic                           snap_valid;
	logic                           snap_ready;
	logic [NUM_PRODS*ACC_WIDTH-1:0] snap_re;
	logic [NUM_PRODS*ACC_WIDTH-1:0] snap_im;
	logic                           frame_done;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pipeline
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	corr_tap_line #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_LAGS(NUM_LAGS),
		.QUAD_SHIFT(QUAD_SHIFT)
	) i_tap_line (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.enable_i(enable_i),
		.integ_len_i(integ_len_i),
		.in_valid_i(in_valid_i),
		.in_samp_i(in_samp_i),
		.in_ready_o(in_ready_o),
		.frame_done_i(frame_done),
		.tap_valid_o(tap_valid),
		.taps_o(taps),
		.tap_last_o(tap_last)
	);

	corr_lag_mult #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_LAGS(NUM_LAGS),
		.QUAD_SHIFT(QUAD_SHIFT)
	) i_lag_mult (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.tap_valid_i(tap_valid),
		.taps_i(taps),
		.tap_last_i(tap_last),
		.prod_valid_o(prod_valid),
		.prod_re_o(prod_re),
		.prod_im_o(prod_im),
		.prod_last_o(prod_last)
	);

	corr_accum #(
		.NUM_BASELINES(NUM_BASELINES),
		.NUM_LAGS(NUM_LAGS),
		.ACC_WIDTH(ACC_WIDTH)
	) i_accum (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.prod_valid_i(prod_valid),
		.prod_re_i(prod_re),
		.prod_im_i(prod_im),
		.prod_last_i(prod_last),
		.snap_valid_o(snap_valid),
		.snap_ready_i(snap_ready),
		.snap_re_o(snap_re),
		.snap_im_o(snap_im),
		.frame_done_o(frame_done)
	);

	corr_readout #(
		.NUM_BASELINES(NUM_BASELINES),
		.NUM_LAGS(NUM_LAGS),
		.ACC_WIDTH(ACC_WIDTH)
	) i_readout (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.integ_len_i(integ_len_i),
		.snap_valid_i(snap_valid),
		.snap_re_i(snap_re),
		.snap_im_i(snap_im),
		.snap_ready_o(snap_ready),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_word_o(out_word_o),
		.out_hdr_o(out_hdr_o)
	);

endmodule

// ==== sim/corr_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the lag correlator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORR_MODEL_SVH
`define CORR_MODEL_SVH

logic [NUM_INPUTS-1:0] hist [TAP_DEPTH]; // hist[0] is the newest vector.
int                    sum_re [NUM_PRODS];
int                    sum_im [NUM_PRODS];
int                    frame_fill;
int                    frame_num;
logic [31:0]           exp_word_q [$];
logic                  exp_hdr_q [$];

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// +1 or -1, held inside the signed accumulator range.
function automatic int clamp_step(input int acc, input bit up);
	int hi;
	int lo;
	hi = (1 << (ACC_WIDTH - 1)) - 1;
	lo = -(1 << (ACC_WIDTH - 1));
	if (up) return (acc >= hi) ? hi : acc + 1;
	return (acc <= lo) ? lo : acc - 1;
endfunction

task automatic model_clear();
	for (int t = 0; t < TAP_DEPTH; t++) begin
		hist[t] = '0;
	end
	for (int q = 0; q < NUM_PRODS; q++) begin
		sum_re[q] = 0;
		sum_im[q] = 0;
	end
	frame_fill = 0;
	frame_num = 0;
endtask

// one accepted vector, queues a whole frame once it is complete.
task automatic model_accept(input logic [NUM_INPUTS-1:0] s, input int len);
	int p;
	corr_stream_pkg::corr_word_u w;
	for (int t = TAP_DEPTH - 1; t > 0; t--) begin
		hist[t] = hist[t - 1];
	end
	hist[0] = s;
	p = 0;
	for (int a = 0; a < NUM_INPUTS; a++) begin
		for (int b = a + 1; b < NUM_INPUTS; b++) begin
			for (int k = 0; k < NUM_LAGS; k++) begin
				sum_re[p] = clamp_step(sum_re[p], hist[0][a] == hist[k][b]);
				sum_im[p] = clamp_step(sum_im[p], hist[0][a] == hist[k + QUAD_SHIFT][b]);
				p++;
			end
		end
	end
	frame_fill++;
	if (frame_fill == len) begin
		w.hdr.frame_cnt = 16'(frame_num);
		w.hdr.samp_cnt = 16'(len);
		exp_word_q.push_back(w);
		exp_hdr_q.push_back(1'b1);
		for (int q = 0; q < NUM_PRODS; q++) begin
			w.data.re = 16'(sum_re[q]);
			w.data.im = 16'(sum_im[q]);
			exp_word_q.push_back(w);
			exp_hdr_q.push_back(1'b0);
			sum_re[q] = 0;
			sum_im[q] = 0;
		end
		frame_fill = 0;
		frame_num++;
	end
endtask

`endif

// ==== sim/corr_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the lag correlator, checked against a model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module corr_tb;
	localparam int NUM_INPUTS = 3;
	localparam int NUM_LAGS = 4;
	localparam int QUAD_SHIFT = 1;
	localparam int ACC_WIDTH = 8;
	localparam int TAP_DEPTH = NUM_LAGS + QUAD_SHIFT;
	localparam int NUM_PRODS = NUM_INPUTS * (NUM_INPUTS - 1) / 2 * NUM_LAGS;
	localparam int FRAME_WORDS = NUM_PRODS + 1;
	localparam int TOTAL_SAMPLES = 100 + 200 + 150 + 80 + 40; // tests 1 to 5.
	localparam int TOTAL_FRAMES = 5 + 1 + 1 + 4 + 2;
	localparam int TIMEOUT_CYCLES = (TOTAL_SAMPLES + TOTAL_FRAMES * FRAME_WORDS) * 4 + 200;

	logic                        clk;
	logic                        rst_n_i;
	logic                        enable_i;
	logic [15:0]                 integ_len_i;
	logic                        in_valid_i;
	logic [NUM_INPUTS-1:0]       in_samp_i;
	logic                        in_ready_o;
	logic                        out_valid_o;
	logic                        out_ready_i;
	corr_stream_pkg::corr_word_u out_word_o;
	logic                        out_hdr_o;

	logic [31:0] rng_in;
	logic [31:0] rng_bp;
	bit          bp_on;
	int          acc_count;
	int          checks;
	int          errors;
	int          test_err;
	int          cycle_cnt;
	int          close_run;
	int          close_max;
	int          hold;
	int          hdr_seen; // header words sent by the DUT.
	bit          stalled;
	logic [31:0] stall_word;
	int          data_pos;
	logic [31:0] last_data [NUM_PRODS]; // data words of the latest frame.

	`include "corr_model.svh"

	corr_top #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_LAGS(NUM_LAGS),
		.QUAD_SHIFT(QUAD_SHIFT),
		.ACC_WIDTH(ACC_WIDTH)
	) i_dut (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.enable_i(enable_i),
		.integ_len_i(integ_len_i),
		.in_valid_i(in_valid_i),
		.in_samp_i(in_samp_i),
		.in_ready_o(in_ready_o),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_word_o(out_word_o),
		.out_hdr_o(out_hdr_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error at %0d ns: %s", $time, what);
	endtask

	function automatic logic [NUM_INPUTS-1:0] pick_samples(input int kind, input logic [31:0] r);
		case (kind)
			1: return '1; // all inputs equal.
			2: return {r[NUM_INPUTS-1:2], 2'b01}; // input 1 is the inverse of input 0.
			default: return r[NUM_INPUTS-1:0];
		endcase
	endfunction

	// offers samples until n more are accepted.
	task automatic send_samples(input int n, input int kind);
		int  target;
		bit  done;
		target = acc_count + n;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (acc_count >= target) begin
				in_valid_i <= 1'b0;
				done = 1'b1;
			end else begin
				rng_in = xorshift(rng_in);
				in_valid_i <= (rng_in[9:8] != 2'b00);
				in_samp_i <= pick_samples(kind, rng_in);
			end
		end
	endtask

	task automatic offer_disabled(input int n);
		for (int c = 0; c < n; c++) begin
			@(posedge clk);
			enable_i <= 1'b0;
			in_valid_i <= 1'b1;
			rng_in = xorshift(rng_in);
			in_samp_i <= rng_in[NUM_INPUTS-1:0];
		end
		@(posedge clk);
		in_valid_i <= 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_word_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - test_err);
		test_err = errors;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// monitor sampled mid-cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk) begin
		if (rst_n_i) begin
			if (in_valid_i && in_ready_o) begin
				model_accept(in_samp_i, int'(integ_len_i));
				acc_count++;
			end
			if (!enable_i) begin
				check_val("in_ready_o", 32'(in_ready_o), 32'd0);
			end
			close_run = (enable_i && !in_ready_o) ? close_run + 1 : 0;
			if (close_run > close_max) close_max = close_run;
			if (stalled) begin
				check_val("out_valid_o", 32'(out_valid_o), 32'd1);
				check_val("out_word_o", out_word_o, stall_word); // held while stalled.
			end
			if (out_valid_o && out_ready_i) begin
				if (out_hdr_o) hdr_seen++;
				if (exp_word_q.size() == 0) begin
					report_error("output word sent with no frame expected");
				end else begin
					check_val("out_hdr_o", 32'(out_hdr_o), 32'(exp_hdr_q[0]));
					check_val("out_word_o", out_word_o, exp_word_q[0]);
					if (exp_hdr_q[0]) begin
						data_pos = 0;
					end else begin
						last_data[data_pos] = out_word_o;
						data_pos++;
					end
					void'(exp_word_q.pop_front());
					void'(exp_hdr_q.pop_front());
				end
			end
			stalled = out_valid_o && !out_ready_i;
			stall_word = out_word_o;
		end
	end

	// output back-pressure.
	initial begin
		out_ready_i = 1'b1;
		rng_bp = 32'd79;
		forever begin
			@(posedge clk);
			rng_bp = xorshift(rng_bp);
			out_ready_i <= bp_on ? (rng_bp[5:4] == 2'b00) : 1'b1;
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		rst_n_i = 1'b0;
		enable_i = 1'b0;
		integ_len_i = 16'd20;
		in_valid_i = 1'b0;
		in_samp_i = '0;
		rng_in = 32'd79;
		bp_on = 1'b0;
		acc_count = 0;
		checks = 0;
		errors = 0;
		test_err = 0;
		close_run = 0;
		close_max = 0;
		hdr_seen = 0;
		stalled = 1'b0;
		stall_word = '0;
		data_pos = 0;
		model_clear();
		repeat (8) @(posedge clk);
		rst_n_i <= 1'b1;
		enable_i <= 1'b1;

		send_samples(100, 0);
		wait_drain();
		finish_test(1, "random frames");

		integ_len_i <= 16'd200;
		send_samples(200, 1);
		wait_drain();
		for (int q = 0; q < NUM_PRODS; q++) begin
			check_val("clamped data word", last_data[q], 32'h007f007f);
		end
		finish_test(2, "positive saturation");

		integ_len_i <= 16'd150;
		send_samples(150, 2);
		wait_drain();
		for (int q = 0; q < NUM_LAGS; q++) begin
			check_val("clamped data word", last_data[q], 32'hff80ff80); // baseline (0,1).
		end
		finish_test(3, "negative saturation");

		integ_len_i <= 16'd20;
		@(negedge clk);
		bp_on = 1'b1;
		close_max = 0;
		send_samples(80, 0);
		wait_drain();
		@(negedge clk);
		bp_on = 1'b0;
		if (close_max < 8) report_error("input never stalled behind a full readout");
		finish_test(4, "output back-pressure");

		send_samples(10, 0);
		hold = acc_count;
		offer_disabled(15);
		check_val("accepted samples", 32'(acc_count), 32'(hold));
		enable_i <= 1'b1;
		send_samples(30, 0);
		wait_drain();
		check_val("header words", 32'(hdr_seen), 32'(TOTAL_FRAMES));
		finish_test(5, "enable dropped mid-frame");

		$display("summary: %0d checks, %0d errors, %0d frames", checks, errors, frame_num);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+sim
hw/corr_cfg_pkg.sv
hw/corr_stream_pkg.sv
hw/corr_tap_line.sv
hw/corr_lag_mult.sv
hw/corr_accum.sv
hw/corr_readout.sv
hw/corr_top.sv
sim/corr_tb.sv

// ==== Makefile ====
# Verilator build and run of the lag correlator testbench.

TB_TOP  := corr_tb
RTL_TOP := corr_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(RTL_TOP)
	verilator --lint-only --timing -f list.f --top-module $(TB_TOP)

# the run passes only if the log holds the pass line.
sim:
	verilator --binary --timing -f list.f --top-module $(TB_TOP) -o corr_sim
	./obj_dir/corr_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log
